/* flist.f */
+incdir+common
common/aud_pkg.sv
rtl/aud_cmd_decode.sv
aud_dsp/aud_fetch.sv
aud_dsp/aud_interp.sv
rtl/aud_dac_player.sv
rtl/aud_top.sv
testbench/tb_aud_top.sv

/* Makefile */
# Verilator build and run for the audio playback path

VERILATOR ?= verilator
TOP       ?= tb_aud_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_aud_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aud_settings.svh"

module tb_aud_top;

    localparam int MAX_PERIODS = 120; // longest schedule below is under 100 LR periods
    localparam int CYCLE_LIMIT = MAX_PERIODS * 256 + 2048;

    logic                          i_clk = 1'b0;
    logic                          i_rst_n, i_start, i_pause;
    logic [`AUD_SPEED_W-1:0]       i_speed;
    logic                          i_is_slow, i_slow_mode;
    logic [`AUD_ADDR_W-1:0]        i_sram_stop_addr, o_sram_addr;
    logic [`AUD_DATA_W-1:0]        i_sram_data;
    logic                          i_daclrck, i_bclk, o_dacdat;

    logic [7:0]                    ph;      // cycle inside the 256-cycle LR period
    int                            cyc_cnt;
    string                         test_name;
    logic [31:0]                   rng;
    logic [`AUD_DATA_W-1:0]        rx_word;

    // reference model
    logic                          m_run, m_paused, m_slow, m_lin, m_played;
    int                            m_step, m_hmax, m_k;
    logic [`AUD_ADDR_W-1:0]        m_addr;
    logic signed [`AUD_DATA_W-1:0] m_curr, m_next, m_sample;

    aud_top aud_top_inst (.*);

    // every address bit reaches the upper product bits, signs come out mixed
    function automatic logic [`AUD_DATA_W-1:0] mem_word(input logic [`AUD_ADDR_W-1:0] addr);
        logic [31:0] p;
        p = 32'(addr) * 32'h9e37_79b1;
        return p[31:16];
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign i_sram_data = mem_word(o_sram_addr); // zero-latency SRAM

    task automatic report_fail(input string what, input int exp, input int act);
        $display("Fail %s: %s expected %0d got %0d", test_name, what, exp, act);
        $display("Some tests failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    // one LR period of the player rules, run at the start of the LR high half
    task automatic advance_period();
        int   a;
        int   d;
        logic take;
        if (m_run && !m_paused) begin
            if (m_played && m_slow) begin
                if (m_k >= m_hmax) m_k = 0;
                else               m_k = m_k + 1;
            end
            take = !m_slow || (m_k == 0);
            if (take) begin
                a = int'(m_addr) + (m_slow ? 1 : m_step);
                if (a > int'(i_sram_stop_addr)) m_addr = '0;
                else                            m_addr = `AUD_ADDR_W'(a);
                m_curr = m_next;
                m_next = mem_word(m_addr);
            end
            if (m_lin) begin
                d = int'(m_next) - int'(m_curr);
                m_sample = `AUD_DATA_W'(int'(m_curr) + d * m_k / (m_hmax + 1));
            end else begin
                m_sample = m_curr;
            end
        end
        m_played = m_run && !m_paused;
    endtask

    task automatic next_phase(input logic [7:0] p);
        do begin
            @(negedge i_clk);
        end while (ph != p);
        @(posedge i_clk);
        #1;
    endtask

    task automatic wait_periods(input int n);
        repeat (n) next_phase(8'd199);
    endtask

    // strobes land in LR low, cycle 200
    task automatic press_pause();
        next_phase(8'd199);
        i_pause = 1'b1;
        if (m_run) m_paused = !m_paused;
        @(posedge i_clk);
        #1;
        i_pause = 1'b0;
    endtask

    task automatic start_cmd(input int s, input logic slow, input logic lin);
        next_phase(8'd199);
        i_start     = 1'b1;
        i_speed     = `AUD_SPEED_W'(s);
        i_is_slow   = slow;
        i_slow_mode = lin;
        m_run       = 1'b1;
        m_paused    = 1'b1;
        m_step      = s + 1;
        m_hmax      = s;
        m_slow      = slow;
        m_lin       = slow && lin;
        if (!slow) m_k = 0;
        @(posedge i_clk);
        #1;
        i_start = 1'b0;
    endtask

    initial begin
        forever #4 i_clk = ~i_clk;
    end

    // bit clock falls 16 times inside each LR low half
    always @(posedge i_clk) begin
        #1;
        ph        = ph + 8'd1;
        i_daclrck = ~ph[7];
        i_bclk    = ~ph[2];
        cyc_cnt   = cyc_cnt + 1;
        if (cyc_cnt > CYCLE_LIMIT) begin
            $display("Timeout: schedule still running after %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $fatal(1, "run ended by the cycle counter");
        end
    end

    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            assert (o_sram_addr == '0) else report_fail("reset address", 0, int'(o_sram_addr));
            assert (o_dacdat == 1'b0) else report_fail("reset dacdat", 0, int'(o_dacdat));
        end else begin
            if (ph == 8'd0) advance_period();
            if (ph == 8'd64) begin
                assert (o_sram_addr == m_addr)
                    else report_fail("address", int'(m_addr), int'(o_sram_addr));
            end
            if (ph != 8'd0 && !ph[7]) begin
                assert (o_dacdat == 1'b0) else report_fail("dacdat in LR high", 0, int'(o_dacdat));
            end
            if (ph[7] && ph[2:0] == 3'd6) begin // mid bit, two cycles after the shift
                rx_word = {rx_word[`AUD_DATA_W-2:0], o_dacdat};
                if (ph == 8'd254) begin
                    assert (rx_word == m_sample)
                        else report_fail("word", int'(m_sample), int'($signed(rx_word)));
                end
            end
        end
    end

    initial begin
        int s_fast;
        int s_slow;
        ph = 8'd0;
        cyc_cnt = 0;
        test_name = "reset";
        rx_word = '0;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_pause = 1'b0;
        i_speed = '0;
        i_is_slow = 1'b0;
        i_slow_mode = 1'b0;
        i_daclrck = 1'b1;
        i_bclk = 1'b1;
        {m_run, m_slow, m_lin, m_played} = 4'b0000;
        m_paused = 1'b1;
        m_step = 1;
        m_hmax = 0;
        m_k = 0;
        m_addr = '0;
        m_curr = '0;
        m_next = mem_word('0);
        m_sample = '0;
        rng = xorshift32(32'd90570);
        i_sram_stop_addr = `AUD_ADDR_W'(16 + rng % 32);

        repeat (16) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        wait_periods(2);                   // no start yet, address parked

        test_name = "fast";
        rng = xorshift32(rng);
        s_fast = 3 + int'(rng % 5);        // long steps so the stop address wraps
        start_cmd(s_fast, 1'b0, 1'b0);
        wait_periods(2);                   // started, waiting for the first press
        press_pause();
        wait_periods(14);

        test_name = "pause";
        rng = xorshift32(rng);
        wait_periods(int'(rng % 3));
        press_pause();
        wait_periods(3);
        press_pause();
        wait_periods(4);

        test_name = "knobs";               // no start, latched command stays
        i_speed = i_speed + 1'b1;
        i_is_slow = 1'b1;
        i_slow_mode = 1'b1;
        wait_periods(3);

        test_name = "hold";
        rng = xorshift32(rng);
        s_slow = 1 + int'(rng % 7);
        start_cmd(s_slow, 1'b1, 1'b0);
        press_pause();
        wait_periods(3 * (s_slow + 1));

        test_name = "linear";
        rng = xorshift32(rng);
        s_slow = 1 + int'(rng % 7);
        start_cmd(s_slow, 1'b1, 1'b1);
        press_pause();
        wait_periods(3 * (s_slow + 1));

        test_name = "restart";
        rng = xorshift32(rng);
        start_cmd((s_fast + 1 + int'(rng % 7)) % 8, 1'b0, 1'b0);
        press_pause();
        wait_periods(8);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/aud_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aud_settings.svh"

module aud_top (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_start,
    input  logic                          i_pause,
    input  logic [`AUD_SPEED_W-1:0]       i_speed,
    input  logic                          i_is_slow,
    input  logic                          i_slow_mode,
    input  logic [`AUD_ADDR_W-1:0]        i_sram_stop_addr,
    output logic [`AUD_ADDR_W-1:0]        o_sram_addr,
    input  logic signed [`AUD_DATA_W-1:0] i_sram_data,
    input  logic                          i_daclrck,
    input  logic                          i_bclk,
    output logic                          o_dacdat
);

    logic                          run, paused;
    logic [`AUD_SPEED_W:0]         step;
    logic [`AUD_SPEED_W-1:0]       cmd_hold_max;
    aud_pkg::interp_mode_e         cmd_mode;

    logic                          en, calc;
    logic signed [`AUD_DATA_W-1:0] curr, next;
    logic [`AUD_SPEED_W-1:0]       hold_idx, hold_max;
    aud_pkg::interp_mode_e         mode;
    logic signed [`AUD_DATA_W-1:0] sample;

    aud_cmd_decode aud_cmd_decode_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_speed     (i_speed),
        .i_is_slow   (i_is_slow),
        .i_slow_mode (i_slow_mode),
        .o_run       (run),
        .o_paused    (paused),
        .o_step      (step),
        .o_hold_max  (cmd_hold_max),
        .o_mode      (cmd_mode)
    );

    aud_fetch aud_fetch_inst (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_run            (run),
        .i_paused         (paused),
        .i_step           (step),
        .i_hold_max       (cmd_hold_max),
        .i_mode           (cmd_mode),
        .i_daclrck        (i_daclrck),
        .i_sram_data      (i_sram_data),
        .i_sram_stop_addr (i_sram_stop_addr),
        .o_sram_addr      (o_sram_addr),
        .o_en             (en),
        .o_calc           (calc),
        .o_curr           (curr),
        .o_next           (next),
        .o_hold_idx       (hold_idx),
        .o_mode           (mode),
        .o_hold_max       (hold_max)
    );

    aud_interp aud_interp_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_calc     (calc),
        .i_mode     (mode),
        .i_curr     (curr),
        .i_next     (next),
        .i_hold_idx (hold_idx),
        .i_hold_max (hold_max),
        .o_sample   (sample)
    );

    // sample computed in LR high is shifted out in the following LR low
    aud_dac_player aud_dac_player_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_en      (en),
        .i_daclrck (i_daclrck),
        .i_bclk    (i_bclk),
        .i_sample  (sample),
        .o_dacdat  (o_dacdat)
    );

endmodule

`default_nettype wire

/* rtl/aud_dac_player.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aud_settings.svh"

module aud_dac_player (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_en,
    input  logic                   i_daclrck,
    input  logic                   i_bclk,
    input  logic [`AUD_DATA_W-1:0] i_sample,
    output logic                   o_dacdat
);

    localparam int CNT_W = $clog2(`AUD_DATA_W + 1);

    logic                   lrck_q, bclk_q; // last seen codec clocks
    logic                   lr_fall, bclk_fall;
    logic [`AUD_DATA_W-1:0] shift_q;
    logic [CNT_W-1:0]       bit_cnt;

    assign lr_fall   = lrck_q && !i_daclrck;
    assign bclk_fall = bclk_q && !i_bclk;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrck_q   <= 1'b0;
            bclk_q   <= 1'b0;
            bit_cnt  <= CNT_W'(`AUD_DATA_W); // idle as if a word was sent
            o_dacdat <= 1'b0;
        end else begin
            lrck_q <= i_daclrck;
            bclk_q <= i_bclk;
            if (lr_fall) begin
                bit_cnt <= '0;
            end else if (bclk_fall && i_en) begin
                if (bit_cnt != CNT_W'(`AUD_DATA_W)) begin
                    o_dacdat <= shift_q[`AUD_DATA_W-1]; // MSB first
                    bit_cnt  <= bit_cnt + 1'b1;
                end else begin
                    o_dacdat <= 1'b0;
                end
            end else if (!i_en) begin
                o_dacdat <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (lr_fall) begin
            shift_q <= i_sample;
        end else if (bclk_fall && i_en) begin
            shift_q <= {shift_q[`AUD_DATA_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* aud_dsp/aud_interp.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aud_settings.svh"

module aud_interp (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_calc,
    input  aud_pkg::interp_mode_e         i_mode,
    input  logic signed [`AUD_DATA_W-1:0] i_curr,
    input  logic signed [`AUD_DATA_W-1:0] i_next,
    input  logic [`AUD_SPEED_W-1:0]       i_hold_idx,
    input  logic [`AUD_SPEED_W-1:0]       i_hold_max,
    output logic signed [`AUD_DATA_W-1:0] o_sample
);

    logic signed [`AUD_DATA_W:0]    diff;    // 17 bits, no overflow
    logic signed [`AUD_DATA_W+4:0]  prod;    // diff * k
    logic signed [`AUD_SPEED_W+1:0] divisor; // hold_max + 1
    logic signed [`AUD_DATA_W+4:0]  quot;
    logic signed [`AUD_DATA_W+4:0]  ramp;

    always_comb begin
        diff    = i_next - i_curr;
        prod    = diff * $signed({1'b0, i_hold_idx});
        divisor = $signed({2'b00, i_hold_max}) + 2'sd1;
        quot    = prod / divisor;               // signed, truncates toward 0
        ramp    = i_curr + quot;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sample <= '0;
        end else if (i_calc) begin
            if (i_mode == aud_pkg::MODE_LINEAR) begin
                o_sample <= ramp[`AUD_DATA_W-1:0]; // lies between curr and next
            end else begin
                o_sample <= i_curr;                // pass and hold
            end
        end
    end

endmodule

`default_nettype wire

/* aud_dsp/aud_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aud_settings.svh"

module aud_fetch (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_run,
    input  logic                          i_paused,
    input  logic [`AUD_SPEED_W:0]         i_step,
    input  logic [`AUD_SPEED_W-1:0]       i_hold_max,
    input  aud_pkg::interp_mode_e         i_mode,
    input  logic                          i_daclrck,
    input  logic signed [`AUD_DATA_W-1:0] i_sram_data,
    input  logic [`AUD_ADDR_W-1:0]        i_sram_stop_addr,
    output logic [`AUD_ADDR_W-1:0]        o_sram_addr,
    output logic                          o_en,
    output logic                          o_calc,
    output logic signed [`AUD_DATA_W-1:0] o_curr,
    output logic signed [`AUD_DATA_W-1:0] o_next,
    output logic [`AUD_SPEED_W-1:0]       o_hold_idx,
    output aud_pkg::interp_mode_e         o_mode,
    output logic [`AUD_SPEED_W-1:0]       o_hold_max
);

    aud_pkg::fetch_state_e state_r, state_w;

    logic [2:0]              get_cnt_r;  // getdata cycle, saturates at 4
    logic [`AUD_SPEED_W-1:0] hold_idx_r;
    logic [`AUD_ADDR_W-1:0]  addr_r, addr_w;
    logic [`AUD_ADDR_W:0]    addr_sum;   // one spare bit for the overflow
    logic                    is_slow;
    logic                    take;       // this period takes a new sample pair
    logic                    lr_return;

    assign is_slow   = (i_mode != aud_pkg::MODE_PASS);
    assign take      = !is_slow || (hold_idx_r == '0);
    assign lr_return = (state_r == aud_pkg::FS_SENDDATA) && i_daclrck && !i_paused;

    assign o_sram_addr = addr_r;
    assign o_en        = !i_daclrck;     // player owns the LR low half
    assign o_calc      = (state_r == aud_pkg::FS_GETDATA) && (get_cnt_r == 3'd3);
    assign o_hold_idx  = hold_idx_r;
    assign o_mode      = i_mode;
    assign o_hold_max  = i_hold_max;

    always_comb begin
        state_w = state_r;
        case (state_r)
            aud_pkg::FS_IDLE: begin
                if (i_run) state_w = aud_pkg::FS_PAUSE;
            end
            aud_pkg::FS_PAUSE: begin
                // resume only at the start of an LR high half
                if (!i_paused && i_daclrck) state_w = aud_pkg::FS_GETDATA;
            end
            aud_pkg::FS_GETDATA: begin
                if (i_paused)        state_w = aud_pkg::FS_PAUSE;
                else if (!i_daclrck) state_w = aud_pkg::FS_SENDDATA;
            end
            aud_pkg::FS_SENDDATA: begin
                if (i_paused)       state_w = aud_pkg::FS_PAUSE;
                else if (i_daclrck) state_w = aud_pkg::FS_GETDATA;
            end
            default: state_w = aud_pkg::FS_IDLE;
        endcase
    end

    // step on cycle 0, anything past the stop address restarts at 0
    always_comb begin
        addr_sum = {1'b0, addr_r};
        if (state_r == aud_pkg::FS_IDLE) begin
            addr_sum = '0;
        end else if (state_r == aud_pkg::FS_GETDATA && get_cnt_r == 3'd0 && take) begin
            if (is_slow) addr_sum = {1'b0, addr_r} + 1'b1;
            else         addr_sum = {1'b0, addr_r} + i_step;
        end
        if (addr_sum > {1'b0, i_sram_stop_addr}) addr_w = '0;
        else                                     addr_w = addr_sum[`AUD_ADDR_W-1:0];
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r    <= aud_pkg::FS_IDLE;
            get_cnt_r  <= '0;
            hold_idx_r <= '0;
            addr_r     <= '0;
        end else begin
            state_r <= state_w;
            addr_r  <= addr_w;

            if (state_r == aud_pkg::FS_GETDATA) begin
                if (get_cnt_r != 3'd4) get_cnt_r <= get_cnt_r + 3'd1;
            end else begin
                get_cnt_r <= '0;
            end

            // k advances once per LR period, kept across a pause
            if (state_r == aud_pkg::FS_IDLE || !is_slow) begin
                hold_idx_r <= '0;
            end else if (lr_return) begin
                if (hold_idx_r >= i_hold_max) hold_idx_r <= '0;
                else                          hold_idx_r <= hold_idx_r + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == aud_pkg::FS_PAUSE) begin
            o_next <= i_sram_data; // address is stable, keep next current
        end else if (state_r == aud_pkg::FS_GETDATA && get_cnt_r == 3'd2 && take) begin
            o_curr <= o_next;
            o_next <= i_sram_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/aud_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aud_settings.svh"

module aud_cmd_decode (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,     // one-cycle strobe
    input  logic                     i_pause,     // press strobe
    input  logic [`AUD_SPEED_W-1:0]  i_speed,
    input  logic                     i_is_slow,
    input  logic                     i_slow_mode, // 1 = linear
    output logic                     o_run,
    output logic                     o_paused,
    output logic [`AUD_SPEED_W:0]    o_step,
    output logic [`AUD_SPEED_W-1:0]  o_hold_max,
    output aud_pkg::interp_mode_e    o_mode
);

    aud_pkg::interp_mode_e mode_w;

    always_comb begin
        if (!i_is_slow) begin
            mode_w = aud_pkg::MODE_PASS;
        end else if (i_slow_mode) begin
            mode_w = aud_pkg::MODE_LINEAR;
        end else begin
            mode_w = aud_pkg::MODE_HOLD;
        end
    end

    // knobs are sampled only here, later changes wait for the next start
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_run      <= 1'b0;
            o_paused   <= 1'b1;
            o_step     <= {{`AUD_SPEED_W{1'b0}}, 1'b1};
            o_hold_max <= '0;
            o_mode     <= aud_pkg::MODE_PASS;
        end else if (i_start) begin
            o_run      <= 1'b1;
            o_paused   <= 1'b1;                  // play needs a first press
            o_step     <= {1'b0, i_speed} + 1'b1;
            o_hold_max <= i_speed;
            o_mode     <= mode_w;
        end else if (o_run && i_pause) begin
            o_paused   <= ~o_paused;
        end
    end

endmodule

`default_nettype wire

/* common/aud_pkg.sv */
`default_nettype none

package aud_pkg;

    // fetch sequencer states
    typedef enum logic [1:0] {
        FS_IDLE     = 2'd0, // waiting for the first start
        FS_PAUSE    = 2'd1,
        FS_GETDATA  = 2'd2, // LR high, fetch and compute
        FS_SENDDATA = 2'd3  // LR low, player shifts out
    } fetch_state_e;

    // output rule chosen at start
    typedef enum logic [1:0] {
        MODE_PASS   = 2'd0, // fast playback
        MODE_HOLD   = 2'd1, // slow, repeat sample
        MODE_LINEAR = 2'd2  // slow, ramp between samples
    } interp_mode_e;

endpackage

`default_nettype wire

/* common/aud_settings.svh */
`ifndef AUD_SETTINGS_SVH
`define AUD_SETTINGS_SVH

// sample width of the SRAM and the codec
`define AUD_DATA_W 16

// SRAM word address width
`define AUD_ADDR_W 20

// speed code from the player knobs
`define AUD_SPEED_W 3

`endif
